// ==== files.f ====
source/cpu_pkg.sv
source/reg_port_if.sv
source/fetch_unit.sv
source/inst_decoder.sv
source/reg_file.sv
source/alu.sv
source/data_mem.sv
source/cpu_top.sv
tb/tb_checker.sv
tb/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module tb_cpu
out="$(./obj_dir/Vtb_cpu)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Finished with no errors"

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam logic [31:0] SEED = 32'h2760_d030;
    // Up to four cycles per loaded word, then one retire per cycle
    localparam int CYCLE_LIMIT = cpu_pkg::MEM_WORDS * 4 + cpu_pkg::MEM_WORDS + 50;

    logic                CLK, RST, load_req, start;
    cpu_pkg::mem_index_t load_addr;
    cpu_pkg::word_t      load_data;
    logic                load_ack, retire_valid, retire_we, retire_mem_we;
    cpu_pkg::word_t      retire_pc, retire_inst, retire_data, retire_mem_addr;
    cpu_pkg::reg_addr_t  retire_rd;
    logic                done;
    int                  error_count;
    int                  cycles = 0;
    logic [31:0]         lfsr = SEED;
    cpu_pkg::word_t      program_words [cpu_pkg::MEM_WORDS];

    cpu_top uut (.*);

    tb_checker u_check (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois taps 32,22,2,1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic cpu_pkg::word_t r_type_word(input logic [6:0] f7,
            input cpu_pkg::reg_addr_t rs2, input cpu_pkg::reg_addr_t rs1,
            input logic [2:0] f3, input cpu_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
    endfunction

    function automatic cpu_pkg::word_t i_type_word(input logic [11:0] imm,
            input cpu_pkg::reg_addr_t rs1, input logic [2:0] f3,
            input cpu_pkg::reg_addr_t rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic cpu_pkg::word_t s_type_word(input logic [11:0] imm,
            input cpu_pkg::reg_addr_t rs2, input cpu_pkg::reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::OPC_STORE};
    endfunction

    task automatic build_program();
        logic [2:0]         kind, f3;
        logic [6:0]         f7;
        logic [11:0]        imm;
        cpu_pkg::reg_addr_t rd, rs1, rs2;
        for (int i = 0; i < 8; i++) begin
            imm = 12'(take_bits(12));
            program_words[i] = i_type_word(imm, 5'd0, 3'd0, 5'(i + 1), cpu_pkg::OPC_OP_IMM);
        end
        for (int i = 8; i < cpu_pkg::MEM_WORDS; i++) begin
            kind = 3'(take_bits(3));
            f3   = 3'(take_bits(3));
            f7   = (take_bits(1) == 32'd1 && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            imm  = 12'(take_bits(12));
            rd   = 5'(take_bits(4));
            rs1  = 5'(take_bits(4));
            rs2  = 5'(take_bits(4));
            case (kind)
                3'd0, 3'd1: program_words[i] = r_type_word(f7, rs2, rs1, f3, rd);
                3'd2, 3'd3: begin
                    if (f3 == 3'd1 || f3 == 3'd5) imm = {f7, imm[4:0]};  // Shift form
                    program_words[i] = i_type_word(imm, rs1, f3, rd, cpu_pkg::OPC_OP_IMM);
                end
                3'd4: program_words[i] = i_type_word({6'd0, imm[3:0], 2'b00}, 5'd0, 3'b010,
                    rd, cpu_pkg::OPC_LOAD);
                3'd5: program_words[i] = s_type_word({6'd0, imm[3:0], 2'b00}, rs2, 5'd0);
                3'd6: program_words[i] = {imm, rs1, f3, rd, 1'b1, rs2[3:0], 2'b11};  // Unknown
                default: program_words[i] = i_type_word(imm, rs1, 3'd0, 5'd0,
                    cpu_pkg::OPC_OP_IMM);  // addi into x0
            endcase
        end
    endtask

    task automatic load_word(input cpu_pkg::mem_index_t addr, input cpu_pkg::word_t word);
        load_addr = addr;
        load_data = word;
        @(negedge CLK);
        load_req = 1'b1;  // Address and data already stable
        while (!load_ack) @(negedge CLK);
        load_req = 1'b0;
        while (load_ack) @(negedge CLK);
    endtask

    initial begin
        RST       = 1'b1;
        load_req  = 1'b0;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        build_program();
        repeat (3) @(negedge CLK);
        RST = 1'b0;
        for (int i = 0; i < cpu_pkg::MEM_WORDS; i++) begin
            load_word(cpu_pkg::mem_index_t'(i), program_words[i]);
        end
        start = 1'b1;  // One cycle pulse
        @(negedge CLK);
        start = 1'b0;
        while (!done) @(negedge CLK);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire                 CLK,
    input  wire                 RST,
    input  wire                 load_req,
    input  wire                 load_ack,
    input  cpu_pkg::mem_index_t load_addr,
    input  cpu_pkg::word_t      load_data,
    input  wire                 retire_valid,
    input  wire                 retire_we,
    input  wire                 retire_mem_we,
    input  cpu_pkg::reg_addr_t  retire_rd,
    input  cpu_pkg::word_t      retire_pc,
    input  cpu_pkg::word_t      retire_inst,
    input  cpu_pkg::word_t      retire_data,
    input  cpu_pkg::word_t      retire_mem_addr,
    output logic                done,
    output int                  error_count
);

    cpu_pkg::word_t regs [32];
    cpu_pkg::word_t dmem [cpu_pkg::MEM_WORDS];
    cpu_pkg::word_t loaded [cpu_pkg::MEM_WORDS];  // Program as seen on the load port
    string          base_names [8] = '{"add", "sll", "slt", "sltu", "xor", "srl", "or", "and"};
    int             retired, passed, hs_errors;
    logic           prev_rst, prev_req, prev_ack;

    // One instruction against the model registers and data words
    function automatic void execute_reference(input cpu_pkg::word_t w, output logic we,
            output cpu_pkg::reg_addr_t rd, output cpu_pkg::word_t data, output logic mem_we,
            output logic mem_op, output cpu_pkg::word_t addr, output string name);
        cpu_pkg::word_t a, b;
        logic           is_op, is_imm;
        a      = regs[w[19:15]];
        is_op  = (w[6:0] == cpu_pkg::OPC_OP);
        is_imm = (w[6:0] == cpu_pkg::OPC_OP_IMM);
        b      = is_op ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};  // I-form immediate
        rd     = w[11:7];
        we     = 1'b0;
        mem_we = 1'b0;
        mem_op = 1'b0;
        data   = '0;
        addr   = '0;
        name   = "nop";
        if (is_op || is_imm) begin
            case (w[14:12])
                3'd0: data = (is_op && w[30]) ? a - b : a + b;
                3'd1: data = a << b[4:0];
                3'd2: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: data = (a < b) ? 32'd1 : 32'd0;
                3'd4: data = a ^ b;
                3'd5: begin
                    if (w[30]) begin
                        data = $signed(a) >>> b[4:0];  // Sign bit fills
                    end else begin
                        data = a >> b[4:0];
                    end
                end
                3'd6: data = a | b;
                default: data = a & b;
            endcase
            we   = (rd != 5'd0);  // x0 never written
            name = base_names[w[14:12]];
            if (is_op && w[30] && w[14:12] == 3'd0) name = "sub";
            if (w[30] && w[14:12] == 3'd5) name = "sra";
            if (is_imm && w[14:12] == 3'd3) begin
                name = "sltiu";
            end else if (is_imm) begin
                name = {name, "i"};
            end
        end else if (w[6:0] == cpu_pkg::OPC_LOAD) begin
            addr   = a + b;
            data   = dmem[addr[7:2]];
            we     = (rd != 5'd0);
            mem_op = 1'b1;
            name   = "lw";
        end else if (w[6:0] == cpu_pkg::OPC_STORE) begin
            addr   = a + {{20{w[31]}}, w[31:25], w[11:7]};  // S-form immediate
            data   = regs[w[24:20]];
            mem_we = 1'b1;
            mem_op = 1'b1;
            name   = "sw";
        end
    endfunction

    task automatic compare_field(input string test, input string field,
            input cpu_pkg::word_t exp, input cpu_pkg::word_t act, inout int errs);
        if (exp !== act) begin
            $display("FAILED %s %s: expected %h, actual %h", test, field, exp, act);
            errs++;
        end
    endtask

    always @(posedge CLK) begin
        logic               we, mem_we, mem_op;
        cpu_pkg::reg_addr_t rd;
        cpu_pkg::word_t     data, addr;
        string              name, test;
        int                 errs;
        if (RST) begin
            for (int i = 0; i < cpu_pkg::MEM_WORDS; i++) begin
                dmem[i]   = '0;
                loaded[i] = '0;
            end
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            retired     = 0;
            passed      = 0;
            hs_errors   = 0;
            error_count = 0;
            done        = 1'b0;
            prev_rst    = 1'b1;
            prev_req    = 1'b0;
            prev_ack    = 1'b0;
        end else begin
            if (prev_rst && load_ack) begin
                $display("Load handshake error: load_ack is high right after reset");
                hs_errors++;
            end
            if (load_ack && !prev_ack && !prev_req) begin
                $display("Load handshake error: load_ack rose while load_req was low");
                hs_errors++;
            end
            if (!load_ack && prev_ack && prev_req) begin
                $display("Load handshake error: load_ack fell while load_req was still high");
                hs_errors++;
            end
            if (load_req && !load_ack && !retire_valid) loaded[load_addr] = load_data;
            prev_rst = 1'b0;
            prev_req = load_req;
            prev_ack = load_ack;
            if (retire_valid && !done) begin
                execute_reference(loaded[retired], we, rd, data, mem_we, mem_op, addr, name);
                test = $sformatf("#%0d %s", retired, name);
                errs = 0;
                compare_field(test, "pc", cpu_pkg::word_t'(retired * 4), retire_pc, errs);
                compare_field(test, "inst", loaded[retired], retire_inst, errs);
                compare_field(test, "we", 32'(we), 32'(retire_we), errs);
                compare_field(test, "mem_we", 32'(mem_we), 32'(retire_mem_we), errs);
                if (we) compare_field(test, "rd", 32'(rd), 32'(retire_rd), errs);
                if (we || mem_we) compare_field(test, "data", data, retire_data, errs);
                if (mem_op) compare_field(test, "mem_addr", addr, retire_mem_addr, errs);
                if (we) regs[rd] = data;
                if (mem_we) dmem[addr[7:2]] = data;
                if (errs == 0) begin
                    passed++;
                    $display("PASS %s", test);
                end else begin
                    $display("FAIL %s, %0d mismatches", test, errs);
                end
                error_count = error_count + errs;
                retired++;
                if (retired == cpu_pkg::MEM_WORDS) begin
                    if (hs_errors == 0) begin
                        $display("PASS load handshake");
                    end else begin
                        $display("FAIL load handshake, %0d violations", hs_errors);
                    end
                    error_count = error_count + hs_errors;
                    $display("Summary: %0d of %0d instructions passed, %0d errors",
                        passed, retired, error_count);
                    done = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire                 CLK,
    input  wire                 RST,
    input  wire                 load_req,
    input  cpu_pkg::mem_index_t load_addr,
    input  cpu_pkg::word_t      load_data,
    output logic                load_ack,
    input  wire                 start,
    output logic                retire_valid,
    output cpu_pkg::word_t      retire_pc,
    output cpu_pkg::word_t      retire_inst,
    output logic                retire_we,
    output cpu_pkg::reg_addr_t  retire_rd,
    output cpu_pkg::word_t      retire_data,
    output logic                retire_mem_we,
    output cpu_pkg::word_t      retire_mem_addr
);

    logic             run;
    cpu_pkg::word_t   pc, inst;
    cpu_pkg::alu_op_t alu_op;
    cpu_pkg::word_t   alu_a, alu_b, alu_y;
    cpu_pkg::word_t   mem_addr, mem_wdata, mem_rdata;
    logic             mem_we;

    reg_port_if rport ();

    fetch_unit u_fetch (
        .CLK(CLK), .RST(RST),
        .load_req(load_req), .load_addr(load_addr), .load_data(load_data),
        .load_ack(load_ack), .start(start),
        .run(run), .pc(pc), .inst(inst)
    );

    inst_decoder u_dec (
        .run(run), .inst(inst), .rf(rport.dec),
        .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_y(alu_y),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
        .mem_rdata(mem_rdata),
        .retire_we(retire_we), .retire_rd(retire_rd), .retire_data(retire_data)
    );

    reg_file u_rf (.CLK(CLK), .RST(RST), .rf(rport.rf));

    alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

    data_mem u_dmem (
        .CLK(CLK), .addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rdata(mem_rdata)
    );

    // Retire trace of the instruction committing at the next edge
    assign retire_valid    = run;
    assign retire_pc       = pc;
    assign retire_inst     = inst;
    assign retire_mem_we   = mem_we;
    assign retire_mem_addr = mem_addr;

endmodule

`default_nettype wire

// ==== source/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  wire            CLK,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wdata,
    input  wire            we,
    output cpu_pkg::word_t rdata
);

    cpu_pkg::word_t      mem [cpu_pkg::MEM_WORDS];
    cpu_pkg::mem_index_t idx;

    initial begin
        for (int i = 0; i < cpu_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;  // Unwritten words read as zero
        end
    end

    assign idx   = addr[7:2];
    assign rdata = mem[idx];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only low 5 bits shift

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  y = a + b;
            cpu_pkg::ALU_SUB:  y = a - b;
            cpu_pkg::ALU_SLL:  y = a << shamt;
            cpu_pkg::ALU_SLT:  y = {31'd0, $signed(a) < $signed(b)};
            cpu_pkg::ALU_SLTU: y = {31'd0, a < b};
            cpu_pkg::ALU_XOR:  y = a ^ b;
            cpu_pkg::ALU_SRL:  y = a >> shamt;
            cpu_pkg::ALU_SRA:  y = $signed(a) >>> shamt;  // Sign bit fills
            cpu_pkg::ALU_OR:   y = a | b;
            cpu_pkg::ALU_AND:  y = a & b;
            default:           y = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input wire     CLK,
    input wire     RST,
    reg_port_if.rf rf
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we && (rf.rd != '0)) begin
            regs[rf.rd] <= rf.wdata;  // x0 writes dropped
        end
    end

    // x0 reads zero since regs[0] is cleared by reset and never written
    assign rf.rdata1 = regs[rf.rs1];
    assign rf.rdata2 = regs[rf.rs2];

    a_x0_zero: assert property (@(posedge CLK) disable iff (RST)
        (rf.rs1 == '0) |-> (rf.rdata1 == '0))
        else $error("x0 read returned nonzero");

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire                run,
    input  cpu_pkg::word_t     inst,
    reg_port_if.dec            rf,
    output cpu_pkg::alu_op_t   alu_op,
    output cpu_pkg::word_t     alu_a,
    output cpu_pkg::word_t     alu_b,
    input  cpu_pkg::word_t     alu_y,
    output cpu_pkg::word_t     mem_addr,
    output cpu_pkg::word_t     mem_wdata,
    output logic               mem_we,
    input  cpu_pkg::word_t     mem_rdata,
    output logic               retire_we,
    output cpu_pkg::reg_addr_t retire_rd,
    output cpu_pkg::word_t     retire_data
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic           is_op, is_op_imm, is_load, is_store;
    cpu_pkg::word_t imm_i, imm_s;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    assign is_op     = (opcode == cpu_pkg::OPC_OP);
    assign is_op_imm = (opcode == cpu_pkg::OPC_OP_IMM);
    assign is_load   = (opcode == cpu_pkg::OPC_LOAD);
    assign is_store  = (opcode == cpu_pkg::OPC_STORE);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    assign rf.rs1 = inst[19:15];
    assign rf.rs2 = inst[24:20];
    assign rf.rd  = inst[11:7];

    always_comb begin
        alu_op = cpu_pkg::ALU_ADD;  // Loads and stores add the offset
        if (is_op || is_op_imm) begin
            case (funct3)
                cpu_pkg::F3_ADD:  alu_op = (is_op && inst[30]) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                cpu_pkg::F3_SLL:  alu_op = cpu_pkg::ALU_SLL;
                cpu_pkg::F3_SLT:  alu_op = cpu_pkg::ALU_SLT;
                cpu_pkg::F3_SLTU: alu_op = cpu_pkg::ALU_SLTU;
                cpu_pkg::F3_XOR:  alu_op = cpu_pkg::ALU_XOR;
                cpu_pkg::F3_SRL:  alu_op = inst[30] ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
                cpu_pkg::F3_OR:   alu_op = cpu_pkg::ALU_OR;
                cpu_pkg::F3_AND:  alu_op = cpu_pkg::ALU_AND;
                default:          alu_op = cpu_pkg::ALU_ADD;
            endcase
        end
    end

    assign alu_a = rf.rdata1;
    assign alu_b = is_op ? rf.rdata2 : (is_store ? imm_s : imm_i);  // shamt sits in imm low bits

    assign mem_addr  = alu_y;  // Effective address rs1 + imm
    assign mem_wdata = rf.rdata2;
    assign mem_we    = run && is_store;

    // Unknown opcodes fall through with both enables low
    assign rf.we    = run && (is_op || is_op_imm || is_load) && (rf.rd != '0);
    assign rf.wdata = is_load ? mem_rdata : alu_y;

    assign retire_we   = rf.we;
    assign retire_rd   = rf.rd;
    assign retire_data = mem_we ? mem_wdata : rf.wdata;

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire                 CLK,
    input  wire                 RST,
    input  wire                 load_req,
    input  cpu_pkg::mem_index_t load_addr,
    input  cpu_pkg::word_t      load_data,
    output logic                load_ack,
    input  wire                 start,
    output logic                run,
    output cpu_pkg::word_t      pc,
    output cpu_pkg::word_t      inst
);

    cpu_pkg::word_t       imem [cpu_pkg::MEM_WORDS];
    cpu_pkg::fetch_state_t state;
    cpu_pkg::mem_index_t  fetch_idx;
    logic                 load_fire;

    // New request seen while idle in the load phase
    assign load_fire = (state == cpu_pkg::ST_LOAD) && load_req && !load_ack;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state    <= cpu_pkg::ST_LOAD;
            load_ack <= 1'b0;
            pc       <= '0;
        end else begin
            case (state)
                cpu_pkg::ST_LOAD: begin
                    if (load_fire) begin
                        load_ack <= 1'b1;
                    end else if (!load_req) begin
                        load_ack <= 1'b0;  // Final phase of handshake
                    end
                    if (start) begin
                        state    <= cpu_pkg::ST_RUN;
                        load_ack <= 1'b0;
                        pc       <= '0;
                    end
                end
                cpu_pkg::ST_RUN: begin
                    pc <= pc + 32'd4;  // One instruction per cycle, no stall
                end
                default: state <= cpu_pkg::ST_LOAD;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST && load_fire) begin
            imem[load_addr] <= load_data;
        end
    end

    assign fetch_idx = pc[7:2];  // Upper pc bits ignored, wraps at 64
    assign inst      = imem[fetch_idx];
    assign run       = (state == cpu_pkg::ST_RUN);

    // The ack only answers a request that was present at the previous edge
    a_ack_needs_req: assert property (@(posedge CLK) disable iff (RST)
        $rose(load_ack) |-> $past(load_req))
        else $error("load_ack rose without load_req");

endmodule

`default_nettype wire

// ==== source/reg_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface reg_port_if;

    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::word_t     wdata;
    logic               we;      // Commits at the rising edge
    cpu_pkg::word_t     rdata1;  // Combinational read of rs1
    cpu_pkg::word_t     rdata2;

    modport dec (
        output rs1, rs2, rd, wdata, we,
        input  rdata1, rdata2
    );

    modport rf (
        input  rs1, rs2, rd, wdata, we,
        output rdata1, rdata2
    );

endinterface

`default_nettype wire

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;       // Data or instruction word
    typedef logic [4:0]  reg_addr_t;   // Register index
    typedef logic [5:0]  mem_index_t;  // Word index into either memory
    typedef logic [3:0]  alu_op_t;

    localparam int MEM_WORDS = 64;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 values for OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;  // srl, sra and immediate forms
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    typedef enum logic {
        ST_LOAD,  // Program load over the handshake
        ST_RUN
    } fetch_state_t;

endpackage

`default_nettype wire
